// File: sources.f
+incdir+common
common/core_pkg.sv
logic/stage_regs.sv
logic/fetch_unit.sv
decode/inst_decoder.sv
decode/reg_file.sv
execute/alu_unit.sv
logic/hazard_unit.sv
logic/rv_core.sv
verification/rv_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

BUILD_DIR=build
LOG="$BUILD_DIR/sim.log"
mkdir -p "$BUILD_DIR"

verilator --binary --timing --assert -f sources.f --top-module rv_core_tb \
    --Mdir "$BUILD_DIR/obj_dir" -o rv_core_sim

"./$BUILD_DIR/obj_dir/rv_core_sim" | tee "$LOG"

if grep -q "TESTBENCH PASSED" "$LOG"; then
    echo "run_sim: simulation passed"
else
    echo "run_sim: simulation failed, see $LOG"
    exit 1
fi

// File: verification/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module rv_core_tb;
    localparam int max_rows        = 48;
    localparam int num_stores      = 2;
    localparam int num_loads       = 2;
    localparam int load_use_stalls = 2;

    localparam logic [6:0] opc_opimm = 7'b0010011;
    localparam logic [6:0] opc_load  = 7'b0000011;

    logic        clock = 1'b0;
    logic        rst_n = 1'b0;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic        dmem_re;
    logic [31:0] dmem_rdata;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];

    // program table, one row per instruction word
    string       row_name   [0:max_rows-1];
    bit          row_writes [0:max_rows-1];
    logic [4:0]  row_rd     [0:max_rows-1];
    logic [31:0] row_value  [0:max_rows-1];
    int          num_rows;

    string       store_name [0:num_stores-1];
    logic [31:0] store_addr [0:num_stores-1];
    logic [31:0] store_data [0:num_stores-1];
    int          store_ptr;
    int          load_count;

    int          first_retire_row = -1;
    int          first_retire_cycle;
    int          last_retire_row;
    int          last_retire_cycle;

    int          retire_errors;
    int          store_errors;
    int          control_errors;
    int          end_errors;
    int          cycle_count;
    int          timeout_limit;
    bit          seen_retire;

    rv_core DUT (
        .clock(clock), .rst_n(rst_n),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
        .dmem_re(dmem_re), .dmem_rdata(dmem_rdata),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    always #4 clock = ~clock;

    assign imem_data  = (imem_addr < 32'd1024) ? imem[imem_addr[9:2]] : `CORE_NOP;
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < 256; i++)
                dmem[i] <= 32'h5A5A_0000 ^ (i * 4); // pattern follows the byte address
        end else if (dmem_we) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

    function automatic logic [31:0] r_type(input logic [6:0] funct7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] funct3,
                                           input logic [4:0] rd);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] funct3, input logic [4:0] rd,
                                           input logic [6:0] opcode);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] funct3);
        return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    task automatic add_row(input string name, input logic [31:0] inst, input bit writes,
                           input logic [4:0] rd, input logic [31:0] value);
        row_name[num_rows]   = name;
        row_writes[num_rows] = writes;
        row_rd[num_rows]     = rd;
        row_value[num_rows]  = value;
        imem[num_rows]       = inst;
        num_rows++;
    endtask

    // x1 = 5 and x2 = -3 feed most of the ALU rows
    task automatic load_program;
        for (int i = 0; i < 256; i++)
            imem[i] = `CORE_NOP;
        num_rows = 0;
        add_row("addi_pos", i_type(12'd5, 5'd0, 3'b000, 5'd1, opc_opimm), 1'b1, 5'd1, 32'h5);
        add_row("addi_neg", i_type(12'hFFD, 5'd0, 3'b000, 5'd2, opc_opimm), 1'b1, 5'd2,
                32'hFFFF_FFFD);
        add_row("add_fwd", r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1'b1, 5'd3, 32'h2);
        add_row("sub", r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 1'b1, 5'd4, 32'h8);
        add_row("and", r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd5), 1'b1, 5'd5, 32'h5);
        add_row("or", r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd6), 1'b1, 5'd6, 32'hFFFF_FFFD);
        add_row("xor", r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd7), 1'b1, 5'd7, 32'hFFFF_FFF8);
        add_row("slt_signed", r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd8), 1'b1, 5'd8, 32'h1);
        add_row("sltu_unsigned", r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd9), 1'b1, 5'd9, 32'h0);
        add_row("sll", r_type(7'h00, 5'd1, 5'd1, 3'b001, 5'd10), 1'b1, 5'd10, 32'hA0);
        add_row("srl", r_type(7'h00, 5'd1, 5'd2, 3'b101, 5'd11), 1'b1, 5'd11, 32'h07FF_FFFF);
        add_row("sra", r_type(7'h20, 5'd1, 5'd2, 3'b101, 5'd12), 1'b1, 5'd12, 32'hFFFF_FFFF);
        add_row("lui", u_type(20'h12345, 5'd13), 1'b1, 5'd13, 32'h1234_5000);
        add_row("ori_fwd", i_type(12'h678, 5'd13, 3'b110, 5'd13, opc_opimm), 1'b1, 5'd13,
                32'h1234_5678);
        add_row("slti", i_type(12'hFFE, 5'd2, 3'b010, 5'd14, opc_opimm), 1'b1, 5'd14, 32'h1);
        add_row("sltiu", i_type(12'hFFF, 5'd1, 3'b011, 5'd15, opc_opimm), 1'b1, 5'd15, 32'h1);
        add_row("xori", i_type(12'hFFF, 5'd1, 3'b100, 5'd16, opc_opimm), 1'b1, 5'd16,
                32'hFFFF_FFFA);
        add_row("andi", i_type(12'h0F0, 5'd6, 3'b111, 5'd17, opc_opimm), 1'b1, 5'd17, 32'hF0);
        add_row("slli", i_type(12'h01C, 5'd1, 3'b001, 5'd18, opc_opimm), 1'b1, 5'd18,
                32'h5000_0000);
        add_row("srai", i_type(12'h401, 5'd2, 3'b101, 5'd19, opc_opimm), 1'b1, 5'd19,
                32'hFFFF_FFFE);
        add_row("srli", i_type(12'h01C, 5'd2, 3'b101, 5'd20, opc_opimm), 1'b1, 5'd20, 32'hF);
        add_row("x0_target", i_type(12'd7, 5'd1, 3'b000, 5'd0, opc_opimm), 1'b0, 5'd0, 32'h0);
        add_row("base_addr", i_type(12'h100, 5'd0, 3'b000, 5'd21, opc_opimm), 1'b1, 5'd21,
                32'h100);
        add_row("sw_word0", s_type(12'h000, 5'd13, 5'd21), 1'b0, 5'd0, 32'h0);
        add_row("sw_word1", s_type(12'h004, 5'd7, 5'd21), 1'b0, 5'd0, 32'h0);
        add_row("lw_word0", i_type(12'h000, 5'd21, 3'b010, 5'd22, opc_load), 1'b1, 5'd22,
                32'h1234_5678);
        add_row("load_use_rs1", r_type(7'h00, 5'd1, 5'd22, 3'b000, 5'd23), 1'b1, 5'd23,
                32'h1234_567D);
        add_row("lw_word1", i_type(12'h004, 5'd21, 3'b010, 5'd24, opc_load), 1'b1, 5'd24,
                32'hFFFF_FFF8);
        add_row("load_use_rs2", r_type(7'h20, 5'd24, 5'd0, 3'b000, 5'd25), 1'b1, 5'd25, 32'h8);
        add_row("beq_taken", b_type(13'd12, 5'd1, 5'd1, 3'b000), 1'b0, 5'd0, 32'h0);
        add_row("beq_shadow0", i_type(12'd1, 5'd0, 3'b000, 5'd26, opc_opimm), 1'b0, 5'd0, 32'h0);
        add_row("beq_shadow1", i_type(12'd2, 5'd0, 3'b000, 5'd26, opc_opimm), 1'b0, 5'd0, 32'h0);
        add_row("bne_not_taken", b_type(13'd12, 5'd1, 5'd1, 3'b001), 1'b0, 5'd0, 32'h0);
        add_row("after_bne", i_type(12'd33, 5'd0, 3'b000, 5'd27, opc_opimm), 1'b1, 5'd27, 32'h21);
        add_row("bne_taken", b_type(13'd12, 5'd2, 5'd1, 3'b001), 1'b0, 5'd0, 32'h0);
        add_row("bne_shadow0", i_type(12'd1, 5'd0, 3'b000, 5'd28, opc_opimm), 1'b0, 5'd0, 32'h0);
        add_row("bne_shadow1", i_type(12'd2, 5'd0, 3'b000, 5'd28, opc_opimm), 1'b0, 5'd0, 32'h0);
        add_row("beq_not_taken", b_type(13'd8, 5'd2, 5'd1, 3'b000), 1'b0, 5'd0, 32'h0);
        add_row("addi_chain", i_type(12'd1, 5'd27, 3'b000, 5'd29, opc_opimm), 1'b1, 5'd29, 32'h22);
        add_row("add_chain", r_type(7'h00, 5'd29, 5'd29, 3'b000, 5'd30), 1'b1, 5'd30, 32'h44);

        store_name[0] = "sw_word0";
        store_addr[0] = 32'h100;
        store_data[0] = 32'h1234_5678;
        store_name[1] = "sw_word1";
        store_addr[1] = 32'h104;
        store_data[1] = 32'hFFFF_FFF8;
    endtask

    task automatic next_retire;
        @(negedge clock);
        while (!wb_valid)
            @(negedge clock);
    endtask

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("timeout: no end of program after %0d cycles", cycle_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    always @(negedge clock) begin
        if (!rst_n) begin
            assert (!wb_valid && !dmem_we && !dmem_re) else begin
                control_errors++;
                $display("strobe raised while reset is asserted");
            end
        end else begin
            if (!seen_retire) begin
                assert (!dmem_we && !dmem_re) else begin
                    control_errors++;
                    $display("memory strobe raised before the first retire");
                end
            end
            if (wb_valid) begin
                assert (wb_rd != 5'd0) else begin
                    control_errors++;
                    $display("retire reported a write to x0");
                end
                seen_retire = 1'b1;
            end
            if (dmem_we) begin
                assert (store_ptr < num_stores) else begin
                    store_errors++;
                    $display("store to %h seen beyond the expected store list", dmem_addr);
                end
                if (store_ptr < num_stores) begin
                    assert (dmem_addr == store_addr[store_ptr] &&
                            dmem_wdata == store_data[store_ptr]) else begin
                        store_errors++;
                        $display("MISMATCH %s: expected [%h]=%h, actual [%h]=%h",
                                 store_name[store_ptr], store_addr[store_ptr],
                                 store_data[store_ptr], dmem_addr, dmem_wdata);
                    end
                end
                store_ptr++;
            end
            if (dmem_re)
                load_count++;
        end
    end

    initial begin
        load_program();
        timeout_limit = 5 * num_rows + 20;
        repeat (3) @(posedge clock);
        rst_n <= 1'b1;

        for (int r = 0; r < num_rows; r++) begin
            if (row_writes[r]) begin
                next_retire();
                if (first_retire_row < 0) begin
                    first_retire_row   = r;
                    first_retire_cycle = cycle_count;
                end
                last_retire_row   = r;
                last_retire_cycle = cycle_count;
                assert (wb_rd == row_rd[r] && wb_data == row_value[r]) else begin
                    retire_errors++;
                    $display("MISMATCH %s: expected x%0d=%h, actual x%0d=%h", row_name[r],
                             row_rd[r], row_value[r], wb_rd, wb_data);
                end
            end
        end

        repeat (8) begin // branch shadows and trailing nops must stay silent
            @(negedge clock);
            assert (!wb_valid) else begin
                end_errors++;
                $display("extra retire of x%0d=%h after the last expected write", wb_rd, wb_data);
            end
        end
        assert (store_ptr == num_stores) else begin
            end_errors++;
            $display("saw %0d stores, expected %0d", store_ptr, num_stores);
        end
        assert (load_count == num_loads) else begin
            end_errors++;
            $display("saw %0d loads, expected %0d", load_count, num_loads);
        end
        // branch shadows are table rows and only the load-use stalls add cycles
        assert (last_retire_cycle - first_retire_cycle ==
                last_retire_row - first_retire_row + load_use_stalls) else begin
            end_errors++;
            $display("MISMATCH retire_span: expected %0d cycles, actual %0d cycles",
                     last_retire_row - first_retire_row + load_use_stalls,
                     last_retire_cycle - first_retire_cycle);
        end

        $display("errors: retire=%0d store=%0d control=%0d end=%0d",
                 retire_errors, store_errors, control_errors, end_errors);
        if (retire_errors + store_errors + control_errors + end_errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end
endmodule

`default_nettype wire

// File: logic/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module rv_core import core_pkg::*; (
    input  wire                   clock,
    input  wire                   rst_n,
    output logic [`CORE_XLEN-1:0] imem_addr,
    input  wire  [`CORE_XLEN-1:0] imem_data,
    output logic [`CORE_XLEN-1:0] dmem_addr,
    output logic [`CORE_XLEN-1:0] dmem_wdata,
    output logic                  dmem_we,
    output logic                  dmem_re,
    input  wire  [`CORE_XLEN-1:0] dmem_rdata,
    output logic                  wb_valid,
    output logic [4:0]            wb_rd,
    output logic [`CORE_XLEN-1:0] wb_data
);
    logic [`CORE_XLEN-1:0] pc;
    if_id_t                if_id_d, if_id_q;
    id_ex_t                id_ex_d, id_ex_q;
    ex_mem_t               ex_mem_d, ex_mem_q;
    mem_wb_t               mem_wb_d, mem_wb_q;
    fwd_sel_e              fwd_a, fwd_b;
    logic                  stall, if_bubble, ex_bubble;
    logic                  branch_taken;
    logic [`CORE_XLEN-1:0] branch_target;
    logic [`CORE_XLEN-1:0] mem_result;

    fetch_unit u_fetch (.clock(clock), .rst_n(rst_n), .stall(stall), .redirect(branch_taken),
                        .redirect_pc(branch_target), .pc(pc));

    assign if_id_d.pc   = pc;
    assign if_id_d.inst = imem_data;

    if_id u_if_id (.clock(clock), .rst_n(rst_n), .bubble(if_bubble), .hold(stall),
                   .d(if_id_d), .q(if_id_q));

    assign id_ex_d.pc = if_id_q.pc;

    inst_decoder u_decoder (.inst(if_id_q.inst), .ctrl(id_ex_d.ctrl), .rs1(id_ex_d.rs1),
                            .rs2(id_ex_d.rs2), .rd(id_ex_d.rd), .imm(id_ex_d.imm));

    reg_file u_regs (.clock(clock), .rst_n(rst_n), .rs1(id_ex_d.rs1), .rs2(id_ex_d.rs2),
                     .rs1_val(id_ex_d.rs1_val), .rs2_val(id_ex_d.rs2_val), .write(mem_wb_q));

    id_ex u_id_ex (.clock(clock), .rst_n(rst_n), .bubble(ex_bubble), .d(id_ex_d), .q(id_ex_q));

    alu_unit u_alu (.stage(id_ex_q), .fwd_a(fwd_a), .fwd_b(fwd_b), .mem_fwd(mem_result),
                    .wb_fwd(mem_wb_q.result), .result(ex_mem_d), .branch_taken(branch_taken),
                    .branch_target(branch_target));

    ex_mem u_ex_mem (.clock(clock), .rst_n(rst_n), .bubble(1'b0), .d(ex_mem_d), .q(ex_mem_q));

    assign mem_result         = ex_mem_q.mem_read ? dmem_rdata : ex_mem_q.alu_result;
    assign mem_wb_d.reg_write = ex_mem_q.reg_write;
    assign mem_wb_d.result    = mem_result;
    assign mem_wb_d.rd        = ex_mem_q.rd;

    mem_wb u_mem_wb (.clock(clock), .rst_n(rst_n), .bubble(1'b0), .d(mem_wb_d), .q(mem_wb_q));

    hazard_unit u_hazard (.id_rs1(id_ex_d.rs1), .id_rs2(id_ex_d.rs2), .ex(id_ex_q),
                          .mem_rd(ex_mem_q.rd), .mem_write_en(ex_mem_q.reg_write),
                          .wb_rd(mem_wb_q.rd), .wb_write_en(mem_wb_q.reg_write),
                          .branch_taken(branch_taken), .fwd_a(fwd_a), .fwd_b(fwd_b),
                          .stall(stall), .if_bubble(if_bubble), .ex_bubble(ex_bubble));

    assign imem_addr  = pc;
    assign dmem_addr  = ex_mem_q.alu_result;
    assign dmem_wdata = ex_mem_q.store_data;
    assign dmem_we    = ex_mem_q.mem_write;
    assign dmem_re    = ex_mem_q.mem_read;

    assign wb_valid = mem_wb_q.reg_write && (mem_wb_q.rd != 5'd0); // x0 writes never retire
    assign wb_rd    = mem_wb_q.rd;
    assign wb_data  = mem_wb_q.result;
endmodule

`default_nettype wire

// File: logic/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import core_pkg::*; (
    input  wire  [4:0]   id_rs1,
    input  wire  [4:0]   id_rs2,
    input  wire  id_ex_t ex,
    input  wire  [4:0]   mem_rd,
    input  wire          mem_write_en,
    input  wire  [4:0]   wb_rd,
    input  wire          wb_write_en,
    input  wire          branch_taken,
    output fwd_sel_e     fwd_a,
    output fwd_sel_e     fwd_b,
    output logic         stall,
    output logic         if_bubble,
    output logic         ex_bubble
);
    logic mem_live;
    logic wb_live;
    logic load_in_ex;

    assign mem_live   = mem_write_en && (mem_rd != 5'd0);
    assign wb_live    = wb_write_en && (wb_rd != 5'd0);
    assign load_in_ex = ex.ctrl.mem_read && (ex.rd != 5'd0);

    // memory stage is younger than writeback, so it is checked first
    assign fwd_a = (mem_live && mem_rd == ex.rs1) ? fwd_mem :
                   (wb_live && wb_rd == ex.rs1)   ? fwd_wb  : fwd_reg;
    assign fwd_b = (mem_live && mem_rd == ex.rs2) ? fwd_mem :
                   (wb_live && wb_rd == ex.rs2)   ? fwd_wb  : fwd_reg;

    assign stall     = load_in_ex && (ex.rd == id_rs1 || ex.rd == id_rs2);
    assign if_bubble = branch_taken;
    assign ex_bubble = branch_taken || stall;
endmodule

`default_nettype wire

// File: execute/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module alu_unit import core_pkg::*; (
    input  wire  id_ex_t          stage,
    input  wire  fwd_sel_e        fwd_a,
    input  wire  fwd_sel_e        fwd_b,
    input  wire  [`CORE_XLEN-1:0] mem_fwd,
    input  wire  [`CORE_XLEN-1:0] wb_fwd,
    output ex_mem_t               result,
    output logic                  branch_taken,
    output logic [`CORE_XLEN-1:0] branch_target
);
    logic [`CORE_XLEN-1:0] op_a;
    logic [`CORE_XLEN-1:0] rs2_fwd;   // forwarded rs2, also the store data
    logic [`CORE_XLEN-1:0] op_b;
    logic [4:0]            shamt;
    logic [`CORE_XLEN-1:0] alu_out;

    assign op_a    = (fwd_a == fwd_mem) ? mem_fwd : (fwd_a == fwd_wb) ? wb_fwd : stage.rs1_val;
    assign rs2_fwd = (fwd_b == fwd_mem) ? mem_fwd : (fwd_b == fwd_wb) ? wb_fwd : stage.rs2_val;
    assign op_b    = stage.ctrl.use_imm ? stage.imm : rs2_fwd;
    assign shamt   = op_b[4:0];

    always_comb begin
        case (stage.ctrl.alu_op)
            alu_sub:  alu_out = op_a - op_b;
            alu_and:  alu_out = op_a & op_b;
            alu_or:   alu_out = op_a | op_b;
            alu_xor:  alu_out = op_a ^ op_b;
            alu_sll:  alu_out = op_a << shamt;
            alu_srl:  alu_out = op_a >> shamt;
            alu_sra:  alu_out = $signed(op_a) >>> shamt;
            alu_slt:  alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_out = {31'd0, op_a < op_b};
            default:  alu_out = op_a + op_b;
        endcase
    end

    assign branch_taken  = stage.ctrl.branch && ((op_a == rs2_fwd) != stage.ctrl.branch_ne);
    assign branch_target = stage.pc + stage.imm;

    assign result.reg_write  = stage.ctrl.reg_write;
    assign result.mem_read   = stage.ctrl.mem_read;
    assign result.mem_write  = stage.ctrl.mem_write;
    assign result.alu_result = alu_out;
    assign result.store_data = rs2_fwd;
    assign result.rd         = stage.rd;
endmodule

`default_nettype wire

// File: decode/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module reg_file import core_pkg::*; (
    input  wire                   clock,
    input  wire                   rst_n,
    input  wire  [4:0]            rs1,
    input  wire  [4:0]            rs2,
    output logic [`CORE_XLEN-1:0] rs1_val,
    output logic [`CORE_XLEN-1:0] rs2_val,
    input  wire  mem_wb_t         write
);
    logic [`CORE_XLEN-1:0] regs [`CORE_REGS-1:1]; // x0 has no storage
    logic                  wr_en;

    assign wr_en = write.reg_write && (write.rd != 5'd0);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `CORE_REGS; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[write.rd] <= write.result;
        end
    end

    // a write in the same cycle shows up on the read port right away
    assign rs1_val = (rs1 == 5'd0) ? '0 :
                     (wr_en && write.rd == rs1) ? write.result : regs[rs1];
    assign rs2_val = (rs2 == 5'd0) ? '0 :
                     (wr_en && write.rd == rs2) ? write.result : regs[rs2];
endmodule

`default_nettype wire

// File: decode/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module inst_decoder import core_pkg::*; (
    input  wire  [`CORE_XLEN-1:0] inst,
    output ctrl_t                 ctrl,
    output logic [4:0]            rs1,
    output logic [4:0]            rs2,
    output logic [4:0]            rd,
    output logic [`CORE_XLEN-1:0] imm
);
    opcode_e               opcode;
    logic [2:0]            funct3;
    logic                  alt;       // funct7 bit 5 picks sub and sra
    alu_op_e               arith_op;
    logic [`CORE_XLEN-1:0] imm_i;
    logic [`CORE_XLEN-1:0] imm_s;
    logic [`CORE_XLEN-1:0] imm_b;
    logic [`CORE_XLEN-1:0] imm_u;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign alt    = inst[30];
    assign rd     = inst[11:7];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};

    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == op_op && alt) ? alu_sub : alu_add;
            3'b001:  arith_op = alu_sll;
            3'b010:  arith_op = alu_slt;
            3'b011:  arith_op = alu_sltu;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = alt ? alu_sra : alu_srl;
            3'b110:  arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    end

    // unused source fields read as x0 so the hazard logic ignores them
    always_comb begin
        ctrl = '0;
        rs1  = inst[19:15];
        rs2  = 5'd0;
        imm  = imm_i;
        case (opcode)
            op_lui: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                rs1            = 5'd0;
                imm            = imm_u;
            end
            op_opimm: begin
                ctrl.alu_op    = arith_op;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            op_op: begin
                ctrl.alu_op    = arith_op;
                ctrl.reg_write = 1'b1;
                rs2            = inst[24:20];
            end
            op_load: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
            end
            op_store: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
                rs2            = inst[24:20];
                imm            = imm_s;
            end
            op_branch: begin
                ctrl.branch    = (funct3[2:1] == 2'b00); // only beq and bne
                ctrl.branch_ne = (funct3 == 3'b001);
                rs2            = inst[24:20];
                imm            = imm_b;
            end
            default: rs1 = 5'd0;
        endcase
    end
endmodule

`default_nettype wire

// File: logic/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module fetch_unit (
    input  wire                        clock,
    input  wire                        rst_n,
    input  wire                        stall,
    input  wire                        redirect,
    input  wire  [`CORE_XLEN-1:0]      redirect_pc,
    output logic [`CORE_XLEN-1:0]      pc
);
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n)
            pc <= `CORE_RESET_PC;
        else if (redirect)
            pc <= redirect_pc; // taken branch wins over a stall
        else if (!stall)
            pc <= pc + `CORE_XLEN'd4;
    end
endmodule

`default_nettype wire

// File: logic/stage_regs.sv
`timescale 1ns/1ps
`default_nettype none

module if_id import core_pkg::*; (
    input  wire     clock,
    input  wire     rst_n,
    input  wire     bubble,
    input  wire     hold,
    input  wire     if_id_t d,
    output if_id_t  q
);
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n)
            q <= '0;
        else if (bubble)
            q <= '0; // a flush beats a load-use hold
        else if (!hold)
            q <= d;
    end
endmodule

module id_ex import core_pkg::*; (
    input  wire     clock,
    input  wire     rst_n,
    input  wire     bubble,
    input  wire     id_ex_t d,
    output id_ex_t  q
);
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n)
            q <= '0;
        else
            q <= bubble ? '0 : d;
    end
endmodule

module ex_mem import core_pkg::*; (
    input  wire     clock,
    input  wire     rst_n,
    input  wire     bubble,
    input  wire     ex_mem_t d,
    output ex_mem_t q
);
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n)
            q <= '0;
        else
            q <= bubble ? '0 : d;
    end
endmodule

module mem_wb import core_pkg::*; (
    input  wire     clock,
    input  wire     rst_n,
    input  wire     bubble,
    input  wire     mem_wb_t d,
    output mem_wb_t q
);
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n)
            q <= '0;
        else
            q <= bubble ? '0 : d;
    end
endmodule

`default_nettype wire

// File: common/core_pkg.sv
`default_nettype none

`include "core_defines.svh"

package core_pkg;

    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_opimm  = 7'b0010011,
        op_op     = 7'b0110011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu
    } alu_op_e;

    typedef enum logic [1:0] {
        fwd_reg = 2'd0,
        fwd_mem = 2'd1,
        fwd_wb  = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;   // second operand is the immediate
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    branch_ne; // taken on inequality
    } ctrl_t;

    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        logic [`CORE_XLEN-1:0] inst;
    } if_id_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [`CORE_XLEN-1:0] pc;
        logic [`CORE_XLEN-1:0] rs1_val;
        logic [`CORE_XLEN-1:0] rs2_val;
        logic [`CORE_XLEN-1:0] imm;
        logic [4:0]            rs1;
        logic [4:0]            rs2;
        logic [4:0]            rd;
    } id_ex_t;

    typedef struct packed {
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        logic [`CORE_XLEN-1:0] alu_result;
        logic [`CORE_XLEN-1:0] store_data;
        logic [4:0]            rd;
    } ex_mem_t;

    typedef struct packed {
        logic                  reg_write;
        logic [`CORE_XLEN-1:0] result;
        logic [4:0]            rd;
    } mem_wb_t;

endpackage

`default_nettype wire

// File: common/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// data path and address width
`define CORE_XLEN 32

`define CORE_REGS 32

`define CORE_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define CORE_NOP 32'h0000_0013

`endif
